/* src/vga_game_pkg.sv */
package vga_game_pkg;

    // Bus and datapath widths
    localparam int COORD_W     = 11;
    localparam int CHAN_W      = 8;
    localparam int DATA_W      = 16;
    localparam int ADDR_W      = 4;
    localparam int SAMPLE_W    = 16;
    localparam int NUM_SAMPLES = 16;

    // Scene geometry
    localparam int SPRITE_SIZE = 32;
    localparam int FONT_SIZE   = 8;
    localparam int STRIPE_GAP  = 20;

    // Magenta marks a hidden sprite
    localparam logic [15:0] TRANSPARENT_KEY = 16'hF81F;

    // Colours as {r, g, b}
    localparam logic [3*CHAN_W-1:0] SKY_DAY      = 24'h87CEEB;
    localparam logic [3*CHAN_W-1:0] SKY_NIGHT    = 24'h0A0A28;
    localparam logic [3*CHAN_W-1:0] GROUND_LIGHT = 24'h8B4513;
    localparam logic [3*CHAN_W-1:0] GROUND_DARK  = 24'h64280A;
    localparam logic [3*CHAN_W-1:0] LINE_COLOR   = 24'h000000;
    localparam logic [3*CHAN_W-1:0] DIGIT_COLOR  = 24'h000000;

    // Register map
    localparam logic [ADDR_W-1:0] REG_PLAYER_X     = 4'd0;
    localparam logic [ADDR_W-1:0] REG_PLAYER_Y     = 4'd1;
    localparam logic [ADDR_W-1:0] REG_PLAYER_COLOR = 4'd2;
    localparam logic [ADDR_W-1:0] REG_SCORE        = 4'd3;
    localparam logic [ADDR_W-1:0] REG_SCORE_X      = 4'd4;
    localparam logic [ADDR_W-1:0] REG_SCORE_Y      = 4'd5;
    localparam logic [ADDR_W-1:0] REG_SFX_PLAY     = 4'd6;

    typedef union packed {
        logic [15:0] word;
        struct packed {
            logic [4:0] red;
            logic [5:0] green;
            logic [4:0] blue;
        } field;
    } pixel565_u;

endpackage

/* src/raster_if.sv */
`timescale 1ns/1ps

interface raster_if;

    logic [vga_game_pkg::COORD_W-1:0] h;
    logic [vga_game_pkg::COORD_W-1:0] v;
    logic                             blank_n;
    logic                             hs;
    logic                             vs;
    // Last pixel of the frame
    logic                             frame_end;

    modport source (output h, v, blank_n, hs, vs, frame_end);

    modport sink (input h, v, blank_n, hs, vs, frame_end);

endinterface

/* src/scene_if.sv */
`timescale 1ns/1ps

interface scene_if;

    logic [vga_game_pkg::COORD_W-1:0] player_x;
    logic [vga_game_pkg::COORD_W-1:0] player_y;
    vga_game_pkg::pixel565_u          player_color;
    // Digit 0 to 9
    logic [3:0]                       score;
    logic [vga_game_pkg::COORD_W-1:0] score_x;
    logic [vga_game_pkg::COORD_W-1:0] score_y;

    modport source (output player_x, player_y, player_color, score, score_x, score_y);

    modport sink (input player_x, player_y, player_color, score, score_x, score_y);

endinterface

/* src/vga_timing.sv */
`timescale 1ns/1ps

module vga_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int H_FRONT  = 32,
    parameter int H_SYNC   = 192,
    parameter int H_BACK   = 96,
    parameter int V_ACTIVE = 480,
    parameter int V_FRONT  = 10,
    parameter int V_SYNC   = 2,
    parameter int V_BACK   = 33
) (
    input  logic     clk,
    input  logic     reset,
    raster_if.source raster
);

    localparam int CW      = vga_game_pkg::COORD_W;
    localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

    logic [CW-1:0] h_count;
    logic [CW-1:0] v_count;
    logic          line_end;
    logic          field_end;

    assign line_end  = (h_count == CW'(H_TOTAL - 1));
    assign field_end = (v_count == CW'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            h_count <= '0;
            v_count <= '0;
        end else if (line_end) begin
            h_count <= '0;
            v_count <= field_end ? '0 : v_count + 1'b1;
        end else begin
            h_count <= h_count + 1'b1;
        end
    end

    assign raster.h         = h_count;
    assign raster.v         = v_count;
    // Both syncs are active low
    assign raster.hs        = !((h_count >= H_ACTIVE + H_FRONT) &&
                                (h_count < H_ACTIVE + H_FRONT + H_SYNC));
    assign raster.vs        = !((v_count >= V_ACTIVE + V_FRONT) &&
                                (v_count < V_ACTIVE + V_FRONT + V_SYNC));
    assign raster.blank_n   = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);
    assign raster.frame_end = line_end && field_end;

endmodule

/* src/register_bank.sv */
`timescale 1ns/1ps

module register_bank (
    input  logic                             clk,
    input  logic                             reset,
    input  logic                             chipselect,
    input  logic                             write,
    input  logic [vga_game_pkg::ADDR_W-1:0]  address,
    input  logic [vga_game_pkg::DATA_W-1:0]  writedata,
    scene_if.source                          scene,
    output logic                             sfx_start
);

    localparam int CW = vga_game_pkg::COORD_W;

    logic wr_en;

    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            scene.player_x          <= '0;
            scene.player_y          <= '0;
            // Sprite starts hidden
            scene.player_color.word <= vga_game_pkg::TRANSPARENT_KEY;
            scene.score             <= '0;
            scene.score_x           <= '0;
            scene.score_y           <= '0;
        end else if (wr_en) begin
            case (address)
                vga_game_pkg::REG_PLAYER_X:     scene.player_x <= writedata[CW-1:0];
                vga_game_pkg::REG_PLAYER_Y:     scene.player_y <= writedata[CW-1:0];
                vga_game_pkg::REG_PLAYER_COLOR: scene.player_color.word <= writedata;
                vga_game_pkg::REG_SCORE:        scene.score <= writedata[3:0];
                vga_game_pkg::REG_SCORE_X:      scene.score_x <= writedata[CW-1:0];
                vga_game_pkg::REG_SCORE_Y:      scene.score_y <= writedata[CW-1:0];
                default: begin
                end
            endcase
        end
    end

    // Any write to the play register fires one pulse
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            sfx_start <= 1'b0;
        end else begin
            sfx_start <= wr_en && (address == vga_game_pkg::REG_SFX_PLAY);
        end
    end

endmodule

/* src/scene_renderer.sv */
`timescale 1ns/1ps

module scene_renderer #(
    parameter int HORIZON    = 280,
    parameter int DAY_FRAMES = 60
) (
    input  logic                             clk,
    input  logic                             reset,
    raster_if.sink                           raster,
    scene_if.sink                            scene,
    output logic [vga_game_pkg::CHAN_W-1:0]  vga_r,
    output logic [vga_game_pkg::CHAN_W-1:0]  vga_g,
    output logic [vga_game_pkg::CHAN_W-1:0]  vga_b,
    output logic                             vga_hs,
    output logic                             vga_vs,
    output logic                             vga_blank_n
);

    localparam int FRAME_W = $clog2(DAY_FRAMES + 1);

    // 8x8 glyphs, top row in the high byte
    localparam logic [63:0] FONT [10] = '{
        64'h3C666E7E76663C00, 64'h1838181818187E00, 64'h3C66061C30667E00,
        64'h3C66061C06663C00, 64'h0C1C2C4C7E0C0C00, 64'h7E607C0606663C00,
        64'h3C66607C66663C00, 64'h7E060C1830303000, 64'h3C66663C66663C00,
        64'h3C66663E06663C00
    };

    logic [FRAME_W-1:0]                   frame_cnt;
    logic                                 night;
    logic                                 in_sprite;
    logic                                 in_digit;
    logic [vga_game_pkg::COORD_W-1:0]     dx;
    logic [vga_game_pkg::COORD_W-1:0]     dy;
    logic [63:0]                          glyph;
    logic [3*vga_game_pkg::CHAN_W-1:0]    pix;

    // Sky flips every DAY_FRAMES frames
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_cnt <= '0;
            night     <= 1'b0;
        end else if (raster.frame_end) begin
            if (frame_cnt == FRAME_W'(DAY_FRAMES - 1)) begin
                frame_cnt <= '0;
                night     <= ~night;
            end else begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    assign in_sprite = (raster.h >= scene.player_x) &&
                       (raster.h < scene.player_x + vga_game_pkg::SPRITE_SIZE) &&
                       (raster.v >= scene.player_y) &&
                       (raster.v < scene.player_y + vga_game_pkg::SPRITE_SIZE) &&
                       (scene.player_color.word != vga_game_pkg::TRANSPARENT_KEY);

    assign dx       = raster.h - scene.score_x;
    assign dy       = raster.v - scene.score_y;
    assign glyph    = (scene.score <= 4'd9) ? FONT[scene.score] : '0;
    assign in_digit = (raster.h >= scene.score_x) &&
                      (raster.h < scene.score_x + vga_game_pkg::FONT_SIZE) &&
                      (raster.v >= scene.score_y) &&
                      (raster.v < scene.score_y + vga_game_pkg::FONT_SIZE);

    // Layers in paint order, later ones win
    always_comb begin
        if (raster.v < HORIZON) begin
            pix = night ? vga_game_pkg::SKY_NIGHT : vga_game_pkg::SKY_DAY;
        end else if (raster.v == HORIZON) begin
            pix = vga_game_pkg::LINE_COLOR;
        end else if (raster.v <= HORIZON + vga_game_pkg::STRIPE_GAP) begin
            pix = vga_game_pkg::GROUND_LIGHT;
        end else begin
            pix = vga_game_pkg::GROUND_DARK;
        end
        if (in_sprite) begin
            // RGB565 widened by zero fill
            pix = {scene.player_color.field.red, 3'b000,
                   scene.player_color.field.green, 2'b00,
                   scene.player_color.field.blue, 3'b000};
        end
        if (in_digit && glyph[6'd63 - {dy[2:0], dx[2:0]}]) begin
            pix = vga_game_pkg::DIGIT_COLOR;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {vga_r, vga_g, vga_b} <= '0;
            vga_hs      <= 1'b1;
            vga_vs      <= 1'b1;
            vga_blank_n <= 1'b0;
        end else begin
            {vga_r, vga_g, vga_b} <= raster.blank_n ? pix : '0;
            vga_hs      <= raster.hs;
            vga_vs      <= raster.vs;
            vga_blank_n <= raster.blank_n;
        end
    end

endmodule

/* src/audio_player.sv */
`timescale 1ns/1ps

module audio_player #(
    parameter int SAMPLE_DIV = 3125
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               sfx_start,
    input  logic                               audio_ready,
    output logic [vga_game_pkg::SAMPLE_W-1:0]  audio_data,
    output logic                               audio_valid
);

    localparam int AW    = $clog2(vga_game_pkg::NUM_SAMPLES);
    localparam int DIV_W = $clog2(SAMPLE_DIV + 1);

    logic [vga_game_pkg::SAMPLE_W-1:0] rom [vga_game_pkg::NUM_SAMPLES];
    logic [AW-1:0]                     addr;
    logic [DIV_W-1:0]                  div_cnt;
    logic                              playing;
    logic                              restart_pending;

    initial begin
        $readmemh("src/sfx_samples.hex", rom);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            addr            <= '0;
            div_cnt         <= '0;
            playing         <= 1'b0;
            restart_pending <= 1'b0;
            audio_valid     <= 1'b0;
        end else if (audio_valid) begin
            // Divider holds while a sample waits
            if (audio_ready) begin
                audio_valid     <= 1'b0;
                restart_pending <= 1'b0;
                if (sfx_start || restart_pending) begin
                    addr <= '0;
                end else if (addr == AW'(vga_game_pkg::NUM_SAMPLES - 1)) begin
                    playing <= 1'b0;
                end else begin
                    addr <= addr + 1'b1;
                end
            end else if (sfx_start) begin
                restart_pending <= 1'b1;
            end
        end else if (sfx_start) begin
            playing <= 1'b1;
            addr    <= '0;
            div_cnt <= '0;
        end else if (playing) begin
            if (div_cnt == DIV_W'(SAMPLE_DIV - 1)) begin
                div_cnt     <= '0;
                audio_valid <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // Sample register loads only when a new sample is presented
    always_ff @(posedge clk) begin
        if (!audio_valid && !sfx_start && playing && div_cnt == DIV_W'(SAMPLE_DIV - 1)) begin
            audio_data <= rom[addr];
        end
    end

endmodule

/* src/vga_game_top.sv */
`timescale 1ns/1ps

module vga_game_top #(
    parameter int H_ACTIVE   = 1280,
    parameter int H_FRONT    = 32,
    parameter int H_SYNC     = 192,
    parameter int H_BACK     = 96,
    parameter int V_ACTIVE   = 480,
    parameter int V_FRONT    = 10,
    parameter int V_SYNC     = 2,
    parameter int V_BACK     = 33,
    parameter int HORIZON    = 280,
    parameter int DAY_FRAMES = 60,
    parameter int SAMPLE_DIV = 3125
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               chipselect,
    input  logic                               write,
    input  logic [vga_game_pkg::ADDR_W-1:0]    address,
    input  logic [vga_game_pkg::DATA_W-1:0]    writedata,
    output logic [vga_game_pkg::CHAN_W-1:0]    vga_r,
    output logic [vga_game_pkg::CHAN_W-1:0]    vga_g,
    output logic [vga_game_pkg::CHAN_W-1:0]    vga_b,
    output logic                               vga_hs,
    output logic                               vga_vs,
    output logic                               vga_blank_n,
    output logic [vga_game_pkg::SAMPLE_W-1:0]  audio_data,
    output logic                               audio_valid,
    input  logic                               audio_ready
);

    logic sfx_start;

    raster_if raster ();
    scene_if  scene ();

    vga_timing #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK)
    ) u_timing (
        .clk(clk), .reset(reset), .raster(raster.source)
    );

    register_bank u_regs (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata), .scene(scene.source),
        .sfx_start(sfx_start)
    );

    scene_renderer #(.HORIZON(HORIZON), .DAY_FRAMES(DAY_FRAMES)) u_render (
        .clk(clk), .reset(reset), .raster(raster.sink), .scene(scene.sink),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n)
    );

    audio_player #(.SAMPLE_DIV(SAMPLE_DIV)) u_audio (
        .clk(clk), .reset(reset), .sfx_start(sfx_start), .audio_ready(audio_ready),
        .audio_data(audio_data), .audio_valid(audio_valid)
    );

endmodule

/* testbench/vga_game_checker.sv */
`timescale 1ns/1ps

module vga_game_checker (
    input logic                              clk,
    input logic                              reset,
    input logic                              vga_hs,
    input logic                              vga_blank_n,
    input logic                              audio_valid,
    input logic                              audio_ready,
    input logic [vga_game_pkg::SAMPLE_W-1:0] audio_data
);

    int fail_count = 0;

    // Offered sample holds until the sink takes it
    audio_hold: assert property (@(posedge clk) disable iff (reset)
            (audio_valid && !audio_ready) |=> (audio_valid && $stable(audio_data)))
        else begin
            fail_count++;
            $error("audio_valid or audio_data changed while ready was low");
        end

    // Horizontal sync pulse lies outside the active area
    sync_outside_active: assert property (@(posedge clk) disable iff (reset)
            vga_blank_n |-> vga_hs)
        else begin
            fail_count++;
            $error("vga_hs low during active video");
        end

    audio_idle_in_reset: assert property (@(posedge clk) reset |-> !audio_valid)
        else begin
            fail_count++;
            $error("audio_valid high during reset");
        end

endmodule

bind vga_game_top vga_game_checker chk (
    .clk(clk), .reset(reset), .vga_hs(vga_hs), .vga_blank_n(vga_blank_n),
    .audio_valid(audio_valid), .audio_ready(audio_ready), .audio_data(audio_data)
);

/* testbench/tb_vga_game.sv */
`timescale 1ns/1ps

module tb_vga_game;

    localparam int H_ACTIVE     = 64;
    localparam int H_FRONT      = 8;
    localparam int H_SYNC       = 8;
    localparam int H_BACK       = 8;
    localparam int V_ACTIVE     = 48;
    localparam int V_FRONT      = 2;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 2;
    localparam int HORIZON      = 20;
    localparam int DAY_FRAMES   = 2;
    localparam int SAMPLE_DIV   = 5;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int AUDIO_LIMIT  = 4000;

    localparam logic [23:0] SKY_DAY      = {8'd135, 8'd206, 8'd235};
    localparam logic [23:0] SKY_NIGHT    = {8'd10, 8'd10, 8'd40};
    localparam logic [23:0] GROUND_LIGHT = {8'd139, 8'd69, 8'd19};
    localparam logic [23:0] GROUND_DARK  = {8'd100, 8'd40, 8'd10};
    localparam logic [15:0] KEY          = vga_game_pkg::TRANSPARENT_KEY;

    // Glyph rows top to bottom with the leftmost pixel in the high bit
    localparam logic [63:0] FONT [10] = '{
        64'h3C666E7E76663C00, 64'h1838181818187E00, 64'h3C66061C30667E00,
        64'h3C66061C06663C00, 64'h0C1C2C4C7E0C0C00, 64'h7E607C0606663C00,
        64'h3C66607C66663C00, 64'h7E060C1830303000, 64'h3C66663C66663C00,
        64'h3C66663E06663C00
    };

    logic        clk;
    logic        reset;
    logic        chipselect;
    logic        write;
    logic [3:0]  address;
    logic [15:0] writedata;
    logic [7:0]  vga_r;
    logic [7:0]  vga_g;
    logic [7:0]  vga_b;
    logic        vga_hs;
    logic        vga_vs;
    logic        vga_blank_n;
    logic [15:0] audio_data;
    logic        audio_valid;
    logic        audio_ready;

    logic [31:0] lfsr_state = 32'h9064;
    string       test_name = "reset";
    bit          ready_random;

    // Reference model state
    int          mh;
    int          mv;
    int          frames;
    bit          model_live;
    logic [2:0]  exp_sync;
    logic [23:0] exp_rgb;
    logic [10:0] m_px;
    logic [10:0] m_py;
    logic [10:0] m_sx;
    logic [10:0] m_sy;
    logic [15:0] m_color;
    logic [3:0]  m_score;
    logic [15:0] samples [16];
    int          exp_idx;
    int          accepted;
    int          night_seen;
    bit          sfx_armed;
    bit          restart_req;

    vga_game_top #(
        .H_ACTIVE(H_ACTIVE), .H_FRONT(H_FRONT), .H_SYNC(H_SYNC), .H_BACK(H_BACK),
        .V_ACTIVE(V_ACTIVE), .V_FRONT(V_FRONT), .V_SYNC(V_SYNC), .V_BACK(V_BACK),
        .HORIZON(HORIZON), .DAY_FRAMES(DAY_FRAMES), .SAMPLE_DIV(SAMPLE_DIV)
    ) uut (
        .clk(clk), .reset(reset), .chipselect(chipselect), .write(write),
        .address(address), .writedata(writedata),
        .vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
        .vga_hs(vga_hs), .vga_vs(vga_vs), .vga_blank_n(vga_blank_n),
        .audio_data(audio_data), .audio_valid(audio_valid), .audio_ready(audio_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        int          i;
        value = '0;
        for (i = 0; i < n; i++) begin
            value = {value[30:0], lfsr_state[0]};
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'hA300_0000;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
        end
        return value;
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Errors found");
        $fatal(1, "Run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            abort_run($sformatf("Fail %s expected %0h actual %0h", name, expected, actual));
        end
    endtask

    // Top layer first so the first hit decides
    function automatic logic [23:0] scene_color(input int h, input int v);
        int         dx;
        int         dy;
        logic [7:0] row;
        dx = h - int'(m_sx);
        dy = v - int'(m_sy);
        if (dx >= 0 && dx < 8 && dy >= 0 && dy < 8) begin
            row = FONT[m_score][8*(7-dy) +: 8];
            if (row[7-dx]) begin
                return 24'h000000;
            end
        end
        if (m_color != KEY && h >= int'(m_px) && h < int'(m_px) + 32 &&
                v >= int'(m_py) && v < int'(m_py) + 32) begin
            return {m_color[15:11], 3'b000, m_color[10:5], 2'b00, m_color[4:0], 3'b000};
        end
        if (v < HORIZON) begin
            return ((frames / DAY_FRAMES) % 2 == 1) ? SKY_NIGHT : SKY_DAY;
        end
        if (v == HORIZON) begin
            return 24'h000000;
        end
        return (v <= HORIZON + 20) ? GROUND_LIGHT : GROUND_DARK;
    endfunction

    // Expected outputs for the position before this edge and then advance
    always @(posedge clk) begin
        if (reset) begin
            mh         = 0;
            mv         = 0;
            frames     = 0;
            model_live = 0;
            m_px       = '0;
            m_py       = '0;
            m_sx       = '0;
            m_sy       = '0;
            m_color    = KEY;
            m_score    = '0;
        end else begin
            exp_sync[2] = !(mh >= H_ACTIVE + H_FRONT && mh < H_ACTIVE + H_FRONT + H_SYNC);
            exp_sync[1] = !(mv >= V_ACTIVE + V_FRONT && mv < V_ACTIVE + V_FRONT + V_SYNC);
            exp_sync[0] = (mh < H_ACTIVE) && (mv < V_ACTIVE);
            exp_rgb     = exp_sync[0] ? scene_color(mh, mv) : 24'h000000;
            model_live  = 1;
            if (chipselect && write) begin
                case (address)
                    vga_game_pkg::REG_PLAYER_X:     m_px = writedata[10:0];
                    vga_game_pkg::REG_PLAYER_Y:     m_py = writedata[10:0];
                    vga_game_pkg::REG_PLAYER_COLOR: m_color = writedata;
                    vga_game_pkg::REG_SCORE:        m_score = writedata[3:0];
                    vga_game_pkg::REG_SCORE_X:      m_sx = writedata[10:0];
                    vga_game_pkg::REG_SCORE_Y:      m_sy = writedata[10:0];
                    default: begin
                    end
                endcase
            end
            if (mh == H_TOTAL - 1) begin
                mh = 0;
                if (mv == V_TOTAL - 1) begin
                    mv = 0;
                    frames++;
                end else begin
                    mv++;
                end
            end else begin
                mh++;
            end
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge clk) begin
        if (reset) begin
            check_value("reset sync", 3'b110, {vga_hs, vga_vs, vga_blank_n});
            check_value("reset rgb", 0, {vga_r, vga_g, vga_b});
            check_value("reset audio_valid", 0, audio_valid);
        end else begin
            if (model_live) begin
                check_value({test_name, " sync"}, exp_sync, {vga_hs, vga_vs, vga_blank_n});
                check_value({test_name, " rgb"}, exp_rgb, {vga_r, vga_g, vga_b});
                if (vga_blank_n && {vga_r, vga_g, vga_b} == SKY_NIGHT) begin
                    night_seen++;
                end
            end
            if (audio_valid && !sfx_armed) begin
                abort_run("audio_valid went high with no sound effect playing");
            end
            if (audio_valid && audio_ready) begin
                check_value({test_name, " sample"}, samples[exp_idx], audio_data);
                accepted++;
                if (restart_req) begin
                    exp_idx     = 0;
                    restart_req = 0;
                end else if (exp_idx == 15) begin
                    sfx_armed = 0;
                end else begin
                    exp_idx++;
                end
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #1;
        chipselect  = 1'b0;
        write       = 1'b0;
        audio_ready = ready_random ? random_bits(1) : 1'b0;
    endtask

    task automatic bus_write(input logic [3:0] addr, input logic [15:0] data);
        step();
        chipselect = 1'b1;
        write      = 1'b1;
        address    = addr;
        writedata  = data;
        // Restart is only issued while a sample waits for ready
        if (addr == vga_game_pkg::REG_SFX_PLAY) begin
            if (sfx_armed) begin
                restart_req = 1;
            end else begin
                sfx_armed = 1;
                exp_idx   = 0;
            end
        end
    endtask

    task automatic wait_frames(input int n);
        int target;
        int count;
        target = frames + n;
        count  = 0;
        while (frames < target) begin
            if (count == n * FRAME_CYCLES + 100) begin
                abort_run("Timeout: the display did not complete the expected frames");
            end
            step();
            count++;
        end
    endtask

    task automatic wait_accepted(input int total);
        int count;
        count = 0;
        while (accepted < total && sfx_armed) begin
            if (count == AUDIO_LIMIT) begin
                abort_run("Timeout: audio samples were not accepted");
            end
            step();
            count++;
        end
    endtask

    task automatic wait_sound_done();
        int count;
        count = 0;
        while (sfx_armed) begin
            if (count == AUDIO_LIMIT) begin
                abort_run("Timeout: the sound effect did not finish");
            end
            step();
            count++;
        end
    endtask

    task automatic wait_audio_valid();
        int count;
        count = 0;
        while (!audio_valid) begin
            if (count == AUDIO_LIMIT) begin
                abort_run("Timeout: audio_valid never rose");
            end
            step();
            count++;
        end
    endtask

    initial begin
        logic [15:0] colour;
        logic [10:0] x;
        logic [10:0] y;
        int          base;
        reset        = 1'b1;
        chipselect   = 1'b0;
        write        = 1'b0;
        address      = '0;
        writedata    = '0;
        audio_ready  = 1'b0;
        ready_random = 0;
        exp_idx      = 0;
        accepted     = 0;
        night_seen   = 0;
        sfx_armed    = 0;
        restart_req  = 0;
        $readmemh("src/sfx_samples.hex", samples);
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // Transparent sprite while the sky flips to night and back
        test_name = "background";
        wait_frames(2 * DAY_FRAMES + 1);
        check_value("background night_sky", 1, night_seen > 0);

        test_name = "sprite";
        repeat (4) begin
            colour = random_bits(16);
            if (colour == KEY) begin
                colour = colour ^ 16'h0001;
            end
            bus_write(vga_game_pkg::REG_PLAYER_X, random_bits(6));
            bus_write(vga_game_pkg::REG_PLAYER_Y, random_bits(6));
            bus_write(vga_game_pkg::REG_PLAYER_COLOR, colour);
            wait_frames(1);
        end
        bus_write(vga_game_pkg::REG_PLAYER_COLOR, KEY);
        wait_frames(1);

        // Digit drawn on top of a sprite at the same corner
        test_name = "score";
        repeat (4) begin
            x      = random_bits(6);
            y      = random_bits(6);
            colour = random_bits(16) | 16'h0020;
            bus_write(vga_game_pkg::REG_SCORE, random_bits(4) % 10);
            bus_write(vga_game_pkg::REG_SCORE_X, x);
            bus_write(vga_game_pkg::REG_SCORE_Y, y);
            bus_write(vga_game_pkg::REG_PLAYER_X, x);
            bus_write(vga_game_pkg::REG_PLAYER_Y, y);
            bus_write(vga_game_pkg::REG_PLAYER_COLOR, colour);
            wait_frames(1);
        end

        test_name    = "audio";
        ready_random = 1;
        bus_write(vga_game_pkg::REG_SFX_PLAY, random_bits(16));
        wait_sound_done();
        repeat (100) step();

        // Start again while a mid-stream sample is held
        test_name = "restart";
        base      = accepted;
        bus_write(vga_game_pkg::REG_SFX_PLAY, 16'h0001);
        wait_accepted(base + 5);
        ready_random = 0;
        step();
        wait_audio_valid();
        bus_write(vga_game_pkg::REG_SFX_PLAY, 16'h0001);
        repeat (3) step();
        ready_random = 1;
        wait_sound_done();
        repeat (20) step();

        if (uut.chk.fail_count != 0) begin
            abort_run("Bound assertions on the top level failed");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

/* src/sfx_samples.hex */
// One 16-bit two's complement sample per line, in playback order
0000
30FB
5A82
7641
7FFF
7641
5A82
30FB
0000
CF05
A57E
89BF
8001
89BF
A57E
CF05

/* src.f */
src/vga_game_pkg.sv
src/raster_if.sv
src/scene_if.sv
src/vga_timing.sv
src/register_bank.sv
src/scene_renderer.sv
src/audio_player.sv
src/vga_game_top.sv
testbench/vga_game_checker.sv
testbench/tb_vga_game.sv

/* Bender.yml */
package:
  name: vga_game

sources:
  - src/vga_game_pkg.sv
  - src/raster_if.sv
  - src/scene_if.sv
  - src/vga_timing.sv
  - src/register_bank.sv
  - src/scene_renderer.sv
  - src/audio_player.sv
  - src/vga_game_top.sv
  - target: test
    files:
      - testbench/vga_game_checker.sv
      - testbench/tb_vga_game.sv
